//--- hdl/cpuPkg.sv
package cpuPkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	typedef logic [31:0] word;
	typedef logic [4:0] regAddr;
	typedef logic [1:0] stageTime;

	localparam word resetPc = 32'h0000_3000;
	localparam word linkOffset = 32'd8;

	// Source never read by this instruction
	localparam stageTime tUseNone = 2'd3;

	// Opcodes and function codes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	//////////////////////////////////////////////////
	// Operation classes
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSel;

	typedef enum logic [1:0] {
		fwdReg,
		fwdE,
		fwdM,
		fwdW
	} fwdSrc;

	//////////////////////////////////////////////////
	// Pipeline registers
	//////////////////////////////////////////////////
	typedef struct packed {
		aluOp aluOp;
		logic aluImm;
		wbSel wbSel;
		logic regWrite;
		logic memWrite;
		regAddr dest;
		stageTime tNew;
	} ctrlBundle;

	typedef struct packed {
		word pc;
		word instr;
	} fdReg;

	typedef struct packed {
		word pc;
		regAddr rs;
		regAddr rt;
		word rsVal;
		word rtVal;
		word imm;
		ctrlBundle ctrl;
	} deReg;

	typedef struct packed {
		word pc;
		word aluRes;
		regAddr rt;
		word rtVal;
		ctrlBundle ctrl;
	} emReg;

	typedef struct packed {
		word pc;
		word aluRes;
		word memData;
		ctrlBundle ctrl;
	} mwReg;

	typedef struct packed {
		logic taken;
		word target;
	} redirect;

	typedef struct packed {
		word addr;
		word wData;
		logic we;
	} memReq;

	typedef struct packed {
		logic we;
		regAddr addr;
		word data;
		word pc;
	} wbPort;

endpackage

//--- hdl/regFile.sv
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regAddr ra1,
	input cpuPkg::regAddr ra2,
	input cpuPkg::wbPort wb,
	output cpuPkg::word rd1,
	output cpuPkg::word rd2
);
	import cpuPkg::*;

	// No storage behind register 0
	word regs [1:31];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- hdl/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit (
	input logic clk,
	input logic rstN,
	input logic stall,
	input cpuPkg::redirect redir,
	input cpuPkg::word iData,
	output cpuPkg::word iAddr,
	output cpuPkg::fdReg fd
);
	import cpuPkg::*;

	word pc;
	word pcNext;

	// Redirect lands after the delay slot already being fetched
	always_comb begin
		if (redir.taken) begin
			pcNext = redir.target;
		end else begin
			pcNext = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			fd <= '0;
		end else if (!stall) begin
			fd.pc <= pc;
			fd.instr <= iData;
		end
	end

	assign iAddr = pc;

endmodule

//--- hdl/decodeUnit.sv
`timescale 1ns/1ns

module decodeUnit (
	input logic clk,
	input logic rstN,
	input logic stall,
	input cpuPkg::fdReg fd,
	input cpuPkg::fwdSrc fwdD1,
	input cpuPkg::fwdSrc fwdD2,
	input cpuPkg::word eVal,
	input cpuPkg::word mVal,
	input cpuPkg::word wVal,
	input cpuPkg::wbPort wb,
	output cpuPkg::redirect redir,
	output cpuPkg::regAddr rsD,
	output cpuPkg::regAddr rtD,
	output cpuPkg::stageTime tUseRs,
	output cpuPkg::stageTime tUseRt,
	output cpuPkg::deReg de
);
	import cpuPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr rdField;
	logic [15:0] imm16;
	word immExt;
	word pcPlus4;
	word rd1;
	word rd2;
	word rsVal;
	word rtVal;
	ctrlBundle ctrl;
	logic isBeq;
	logic isJal;
	logic isJr;

	function automatic word fwdMux(fwdSrc sel, word regVal, word e, word m, word w);
		case (sel)
			fwdE: return e;
			fwdM: return m;
			fwdW: return w;
			default: return regVal;
		endcase
	endfunction

	assign opcode = fd.instr[31:26];
	assign funct = fd.instr[5:0];
	assign rsD = fd.instr[25:21];
	assign rtD = fd.instr[20:16];
	assign rdField = fd.instr[15:11];
	assign imm16 = fd.instr[15:0];
	assign pcPlus4 = fd.pc + 32'd4;

	regFile regFile_i (
		.clk(clk),
		.rstN(rstN),
		.ra1(rsD),
		.ra2(rtD),
		.wb(wb),
		.rd1(rd1),
		.rd2(rd2)
	);

	//////////////////////////////////////////////////
	// Control decode
	//////////////////////////////////////////////////
	always_comb begin
		ctrl = '0;
		tUseRs = tUseNone;
		tUseRt = tUseNone;
		isBeq = 1'b0;
		isJal = 1'b0;
		isJr = 1'b0;
		immExt = {{16{imm16[15]}}, imm16};
		case (opcode)
			opSpecial: begin
				ctrl.regWrite = 1'b1;
				ctrl.dest = rdField;
				ctrl.tNew = 2'd1;
				tUseRs = 2'd1;
				tUseRt = 2'd1;
				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnSlt: ctrl.aluOp = aluSlt;
					fnJr: begin
						isJr = 1'b1;
						ctrl.regWrite = 1'b0;
						tUseRs = 2'd0;
						tUseRt = tUseNone;
					end
					default: begin
						ctrl.regWrite = 1'b0;
						tUseRs = tUseNone;
						tUseRt = tUseNone;
					end
				endcase
			end
			opOri, opLui: begin
				ctrl.aluOp = (opcode == opLui) ? aluLui : aluOr;
				ctrl.aluImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rtD;
				ctrl.tNew = 2'd1;
				tUseRs = (opcode == opLui) ? tUseNone : 2'd1;
				immExt = (opcode == opLui) ? {imm16, 16'h0000} : {16'h0000, imm16};
			end
			opLw: begin
				ctrl.aluImm = 1'b1;
				ctrl.wbSel = wbMem;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rtD;
				ctrl.tNew = 2'd2;
				tUseRs = 2'd1;
			end
			opSw: begin
				ctrl.aluImm = 1'b1;
				ctrl.memWrite = 1'b1;
				tUseRs = 2'd1;
				tUseRt = 2'd2;
			end
			opBeq: begin
				isBeq = 1'b1;
				tUseRs = 2'd0;
				tUseRt = 2'd0;
			end
			opJal: begin
				isJal = 1'b1;
				ctrl.wbSel = wbLink;
				ctrl.regWrite = 1'b1;
				ctrl.dest = 5'd31;
			end
			default: begin
				ctrl = '0;
			end
		endcase
		// Writes to register 0 are dropped here
		if (!ctrl.regWrite || ctrl.dest == '0) begin
			ctrl.regWrite = 1'b0;
			ctrl.dest = '0;
			ctrl.tNew = '0;
		end
	end

	//////////////////////////////////////////////////
	// Operands and branch resolution
	//////////////////////////////////////////////////
	assign rsVal = fwdMux(fwdD1, rd1, eVal, mVal, wVal);
	assign rtVal = fwdMux(fwdD2, rd2, eVal, mVal, wVal);

	always_comb begin
		redir.taken = 1'b0;
		redir.target = pcPlus4 + {immExt[29:0], 2'b00};
		if (isBeq && rsVal == rtVal) begin
			redir.taken = 1'b1;
		end else if (isJal) begin
			redir.taken = 1'b1;
			redir.target = {pcPlus4[31:28], fd.instr[25:0], 2'b00};
		end else if (isJr) begin
			redir.taken = 1'b1;
			redir.target = rsVal;
		end
	end

	always_ff @(posedge clk) begin
		de.pc <= fd.pc;
		de.rs <= rsD;
		de.rt <= rtD;
		de.rsVal <= rsVal;
		de.rtVal <= rtVal;
		de.imm <= immExt;
		// Bubble on stall
		if (!rstN || stall) begin
			de.ctrl <= '0;
		end else begin
			de.ctrl <= ctrl;
		end
	end

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	input cpuPkg::regAddr rsD,
	input cpuPkg::regAddr rtD,
	input cpuPkg::stageTime tUseRs,
	input cpuPkg::stageTime tUseRt,
	input cpuPkg::deReg de,
	input cpuPkg::emReg em,
	input cpuPkg::mwReg mw,
	output logic stall,
	output cpuPkg::fwdSrc fwdD1,
	output cpuPkg::fwdSrc fwdD2,
	output cpuPkg::fwdSrc fwdE1,
	output cpuPkg::fwdSrc fwdE2,
	output cpuPkg::fwdSrc fwdM2
);
	import cpuPkg::*;

	stageTime tNewE;
	stageTime tNewM;

	// Remaining cycles after n further stages
	function automatic stageTime aged(stageTime t, stageTime n);
		return (t > n) ? stageTime'(t - n) : '0;
	endfunction

	// Youngest stage writing src, register 0 never matches
	function automatic fwdSrc youngest(regAddr src, regAddr dE, regAddr dM, regAddr dW);
		fwdSrc sel;
		sel = fwdReg;
		if (src != '0) begin
			if (src == dE) begin
				sel = fwdE;
			end else if (src == dM) begin
				sel = fwdM;
			end else if (src == dW) begin
				sel = fwdW;
			end
		end
		return sel;
	endfunction

	// Writeback always holds a finished result
	function automatic logic tooEarly(fwdSrc sel, stageTime tUse, stageTime tE, stageTime tM);
		case (sel)
			fwdE: return tUse < tE;
			fwdM: return tUse < tM;
			default: return 1'b0;
		endcase
	endfunction

	assign tNewE = de.ctrl.tNew;
	assign tNewM = aged(em.ctrl.tNew, 2'd1);

	assign fwdD1 = youngest(rsD, de.ctrl.dest, em.ctrl.dest, mw.ctrl.dest);
	assign fwdD2 = youngest(rtD, de.ctrl.dest, em.ctrl.dest, mw.ctrl.dest);
	assign fwdE1 = youngest(de.rs, 5'd0, em.ctrl.dest, mw.ctrl.dest);
	assign fwdE2 = youngest(de.rt, 5'd0, em.ctrl.dest, mw.ctrl.dest);
	assign fwdM2 = youngest(em.rt, 5'd0, 5'd0, mw.ctrl.dest);

	assign stall = tooEarly(fwdD1, tUseRs, tNewE, tNewM)
		|| tooEarly(fwdD2, tUseRt, tNewE, tNewM);

endmodule

//--- hdl/executeUnit.sv
`timescale 1ns/1ns

module executeUnit (
	input logic clk,
	input logic rstN,
	input cpuPkg::deReg de,
	input cpuPkg::fwdSrc fwdE1,
	input cpuPkg::fwdSrc fwdE2,
	input cpuPkg::word mVal,
	input cpuPkg::word wVal,
	output cpuPkg::word eVal,
	output cpuPkg::emReg em
);
	import cpuPkg::*;

	word opA;
	word opB;
	word rtFwd;
	word aluRes;

	// Decode may have picked up a value that was not ready yet
	always_comb begin
		case (fwdE1)
			fwdM: opA = mVal;
			fwdW: opA = wVal;
			default: opA = de.rsVal;
		endcase
		case (fwdE2)
			fwdM: rtFwd = mVal;
			fwdW: rtFwd = wVal;
			default: rtFwd = de.rtVal;
		endcase
		opB = de.ctrl.aluImm ? de.imm : rtFwd;
	end

	//////////////////////////////////////////////////
	// ALU, wrapping arithmetic
	//////////////////////////////////////////////////
	always_comb begin
		case (de.ctrl.aluOp)
			aluSub: aluRes = opA - opB;
			aluAnd: aluRes = opA & opB;
			aluOr: aluRes = opA | opB;
			aluSlt: aluRes = {31'd0, $signed(opA) < $signed(opB)};
			aluLui: aluRes = opB;
			default: aluRes = opA + opB;
		endcase
	end

	// Only a jal result exists this early
	assign eVal = de.pc + linkOffset;

	always_ff @(posedge clk) begin
		em.pc <= de.pc;
		em.aluRes <= aluRes;
		em.rt <= de.rt;
		em.rtVal <= rtFwd;
		if (!rstN) begin
			em.ctrl <= '0;
		end else begin
			em.ctrl <= de.ctrl;
		end
	end

endmodule

//--- hdl/memWriteback.sv
`timescale 1ns/1ns

module memWriteback (
	input logic clk,
	input logic rstN,
	input cpuPkg::emReg em,
	input cpuPkg::fwdSrc fwdM2,
	input cpuPkg::word dRData,
	output cpuPkg::memReq dReq,
	output cpuPkg::word mVal,
	output cpuPkg::word wVal,
	output cpuPkg::mwReg mw,
	output cpuPkg::wbPort wb
);
	import cpuPkg::*;

	word storeData;

	// Late store data, e.g. lw followed by sw of the loaded register
	assign storeData = (fwdM2 == fwdW) ? wVal : em.rtVal;

	assign dReq.addr = em.aluRes;
	assign dReq.wData = storeData;
	assign dReq.we = em.ctrl.memWrite;

	assign mVal = (em.ctrl.wbSel == wbLink) ? em.pc + linkOffset : em.aluRes;

	always_ff @(posedge clk) begin
		mw.pc <= em.pc;
		mw.aluRes <= em.aluRes;
		mw.memData <= dRData;
		if (!rstN) begin
			mw.ctrl <= '0;
		end else begin
			mw.ctrl <= em.ctrl;
		end
	end

	//////////////////////////////////////////////////
	// Writeback
	//////////////////////////////////////////////////
	always_comb begin
		case (mw.ctrl.wbSel)
			wbMem: wVal = mw.memData;
			wbLink: wVal = mw.pc + linkOffset;
			default: wVal = mw.aluRes;
		endcase
	end

	assign wb.we = mw.ctrl.regWrite;
	assign wb.addr = mw.ctrl.dest;
	assign wb.data = wVal;
	assign wb.pc = mw.pc;

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
	input logic clk,
	input logic rstN,
	input cpuPkg::word iData,
	input cpuPkg::word dRData,
	output cpuPkg::word iAddr,
	output cpuPkg::memReq dReq,
	output cpuPkg::wbPort wb
);
	import cpuPkg::*;

	logic stall;
	redirect redir;
	fdReg fd;
	deReg de;
	emReg em;
	mwReg mw;
	regAddr rsD;
	regAddr rtD;
	stageTime tUseRs;
	stageTime tUseRt;
	fwdSrc fwdD1;
	fwdSrc fwdD2;
	fwdSrc fwdE1;
	fwdSrc fwdE2;
	fwdSrc fwdM2;
	word eVal;
	word mVal;
	word wVal;

	fetchUnit fetch_i (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.redir(redir),
		.iData(iData),
		.iAddr(iAddr),
		.fd(fd)
	);

	decodeUnit decode_i (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.fd(fd),
		.fwdD1(fwdD1),
		.fwdD2(fwdD2),
		.eVal(eVal),
		.mVal(mVal),
		.wVal(wVal),
		.wb(wb),
		.redir(redir),
		.rsD(rsD),
		.rtD(rtD),
		.tUseRs(tUseRs),
		.tUseRt(tUseRt),
		.de(de)
	);

	hazardUnit hazard_i (
		.rsD(rsD),
		.rtD(rtD),
		.tUseRs(tUseRs),
		.tUseRt(tUseRt),
		.de(de),
		.em(em),
		.mw(mw),
		.stall(stall),
		.fwdD1(fwdD1),
		.fwdD2(fwdD2),
		.fwdE1(fwdE1),
		.fwdE2(fwdE2),
		.fwdM2(fwdM2)
	);

	executeUnit execute_i (
		.clk(clk),
		.rstN(rstN),
		.de(de),
		.fwdE1(fwdE1),
		.fwdE2(fwdE2),
		.mVal(mVal),
		.wVal(wVal),
		.eVal(eVal),
		.em(em)
	);

	memWriteback memWb_i (
		.clk(clk),
		.rstN(rstN),
		.em(em),
		.fwdM2(fwdM2),
		.dRData(dRData),
		.dReq(dReq),
		.mVal(mVal),
		.wVal(wVal),
		.mw(mw),
		.wb(wb)
	);

endmodule

//--- dv/cpuTop_properties.sv
`timescale 1ns/1ns

module cpuTopProperties (
	input logic clk,
	input logic rstN,
	input cpuPkg::word iAddr,
	input cpuPkg::memReq dReq,
	input cpuPkg::wbPort wb
);

	// Register 0 is never a write target
	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		wb.we |-> wb.addr != 5'd0)
		else $error("register write to register 0 at pc %h", wb.pc);

	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		iAddr[1:0] == 2'b00)
		else $error("instruction address %h not word aligned", iAddr);

	// First cycle out of reset, pipeline holds bubbles
	quietAfterReset: assert property (@(posedge clk)
		$rose(rstN) |-> !wb.we && !dReq.we)
		else $error("register write or store in the first cycle after reset");

endmodule

bind cpuTop cpuTopProperties props_i (
	.clk(clk),
	.rstN(rstN),
	.iAddr(iAddr),
	.dReq(dReq),
	.wb(wb)
);

//--- dv/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	logic clk;
	logic rstN;
	word iData;
	word dRData;
	word iAddr;
	word iOffset;
	memReq dReq;
	wbPort wb;

	word imem [0:255];
	word dmem [0:255];
	word modelMem [0:255];
	word modelRegs [0:31];
	word prog [$];
	wbPort expWb [$];
	wbPort gotWb [$];
	memReq expSt [$];
	memReq gotSt [$];
	word lfsrState = 32'heb58_aac6;
	int cycles = 0;
	int cycleLimit = 200;

	cpuTop dut_i (
		.clk(clk),
		.rstN(rstN),
		.iData(iData),
		.dRData(dRData),
		.iAddr(iAddr),
		.dReq(dReq),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Memories and monitors
	//////////////////////////////////////////////////
	assign iOffset = iAddr - resetPc;
	assign iData = (iOffset < 32'd1024) ? imem[iOffset[9:2]] : '0;
	assign dRData = dmem[dReq.addr[9:2]];

	always @(posedge clk) begin
		if (rstN && dReq.we) begin
			dmem[dReq.addr[9:2]] <= dReq.wData;
			gotSt.push_back(dReq);
		end
		if (rstN && wb.we) begin
			gotWb.push_back(wb);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycles);
			failRun();
		end
	end

	task automatic failRun();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic word randBits(int n);
		word v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrBit()};
		end
		return v;
	endfunction

	// Differs for every word address
	function automatic word fillWord(int i);
		return (word'(i) * 32'h0101_0101) ^ 32'hc3a5_0f1e;
	endfunction

	function automatic word encR(logic [5:0] fn, regAddr rd, regAddr rs, regAddr rt);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word encI(logic [5:0] op, regAddr rt, regAddr rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word encJal(word target);
		return {opJal, target[27:2]};
	endfunction

	task automatic loadConst(regAddr r, word v);
		prog.push_back(encI(opLui, r, 5'd0, v[31:16]));
		prog.push_back(encI(opOri, r, r, v[15:0]));
	endtask

	task automatic loadMemories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : '0;
			dmem[i] = fillWord(i);
		end
	endtask

	//////////////////////////////////////////////////
	// ISA model
	//////////////////////////////////////////////////
	task automatic retire(regAddr dest, word value, word pc);
		wbPort ev;
		if (dest != 5'd0) begin
			modelRegs[dest] = value;
			ev.we = 1'b1;
			ev.addr = dest;
			ev.data = value;
			ev.pc = pc;
			expWb.push_back(ev);
		end
	endtask

	task automatic runModel();
		word pc;
		word nextPc;
		word newNext;
		word pcPlus4;
		word instr;
		word a;
		word b;
		word simm;
		word addr;
		regAddr rt;
		regAddr rd;
		memReq st;
		int steps;
		expWb.delete();
		expSt.delete();
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			modelMem[i] = fillWord(i);
		end
		pc = resetPc;
		nextPc = resetPc + 32'd4;
		steps = 0;
		while (pc - resetPc < word'(4 * prog.size())) begin
			instr = prog[(pc - resetPc) >> 2];
			a = modelRegs[instr[25:21]];
			b = modelRegs[instr[20:16]];
			rt = instr[20:16];
			rd = instr[15:11];
			simm = {{16{instr[15]}}, instr[15:0]};
			pcPlus4 = pc + 32'd4;
			// One delay slot
			newNext = nextPc + 32'd4;
			case (instr[31:26])
				opSpecial: begin
					case (instr[5:0])
						fnAdd: retire(rd, a + b, pc);
						fnSub: retire(rd, a - b, pc);
						fnAnd: retire(rd, a & b, pc);
						fnOr: retire(rd, a | b, pc);
						fnSlt: retire(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, pc);
						fnJr: newNext = a;
						default: begin
						end
					endcase
				end
				opOri: retire(rt, a | {16'h0000, instr[15:0]}, pc);
				opLui: retire(rt, {instr[15:0], 16'h0000}, pc);
				opLw: begin
					addr = a + simm;
					retire(rt, modelMem[addr[9:2]], pc);
				end
				opSw: begin
					addr = a + simm;
					modelMem[addr[9:2]] = b;
					st.addr = addr;
					st.wData = b;
					st.we = 1'b1;
					expSt.push_back(st);
				end
				opBeq: begin
					if (a == b) begin
						newNext = pcPlus4 + {simm[29:0], 2'b00};
					end
				end
				opJal: begin
					retire(5'd31, pc + 32'd8, pc);
					newNext = {pcPlus4[31:28], instr[25:0], 2'b00};
				end
				default: begin
				end
			endcase
			pc = nextPc;
			nextPc = newNext;
			steps++;
			if (steps > 500) begin
				$display("ISA model did not leave the program after %0d steps", steps);
				failRun();
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkWord(string name, word got, word exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkReg(string name, regAddr got, regAddr exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkPc(string name, word got, word exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is pc %h, expected pc %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkReq(string name, memReq got, memReq exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is addr %h data %h we %b, expected addr %h data %h we %b",
				$time, name, got.addr, got.wData, got.we, exp.addr, exp.wData, exp.we);
			failRun();
		end
	endtask

	//////////////////////////////////////////////////
	// Program run
	//////////////////////////////////////////////////
	task automatic startProgram();
		cycleLimit += 4 * prog.size();
		runModel();
		@(posedge clk);
		rstN <= 1'b0;
		repeat (2) @(posedge clk);
		loadMemories();
		repeat (8) @(posedge clk);
		gotWb.delete();
		gotSt.delete();
		rstN <= 1'b1;
	endtask

	task automatic finishProgram();
		while (gotWb.size() < expWb.size() || gotSt.size() < expSt.size()) begin
			@(negedge clk);
		end
		if (gotWb.size() != expWb.size() || gotSt.size() != expSt.size()) begin
			$display("Saw %0d register writes and %0d stores, expected %0d and %0d",
				gotWb.size(), gotSt.size(), expWb.size(), expSt.size());
			failRun();
		end
		foreach (expWb[i]) begin
			checkReg($sformatf("wb.addr (write %0d)", i), gotWb[i].addr, expWb[i].addr);
			checkWord($sformatf("wb.data (write %0d)", i), gotWb[i].data, expWb[i].data);
			checkPc($sformatf("wb.pc (write %0d)", i), gotWb[i].pc, expWb[i].pc);
		end
		foreach (expSt[i]) begin
			checkReq($sformatf("dReq (store %0d)", i), gotSt[i], expSt[i]);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic resetSequence();
		prog.delete();
		for (int r = 1; r <= 4; r++) begin
			prog.push_back(encI(opOri, regAddr'(r), 5'd0, 16'(randBits(16))));
		end
		startProgram();
		// First write four cycles after the first fetch
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			if (i == 0) begin
				checkPc("iAddr", iAddr, resetPc);
			end
			checkFlag("dReq.we", dReq.we, 1'b0);
			checkFlag("wb.we", wb.we, i == 4);
		end
		checkPc("wb.pc", wb.pc, resetPc);
		finishProgram();
	endtask

	task automatic independentAlu();
		prog.delete();
		for (int r = 1; r <= 4; r++) begin
			loadConst(regAddr'(r), randBits(32));
		end
		prog.push_back(encR(fnAdd, 5'd5, 5'd1, 5'd2));
		prog.push_back(encR(fnSub, 5'd6, 5'd3, 5'd4));
		prog.push_back(encR(fnAnd, 5'd7, 5'd1, 5'd3));
		prog.push_back(encR(fnOr, 5'd8, 5'd2, 5'd4));
		prog.push_back(encR(fnSlt, 5'd9, 5'd1, 5'd2));
		prog.push_back(encR(fnSlt, 5'd10, 5'd2, 5'd1));
		prog.push_back(encI(opOri, 5'd11, 5'd3, 16'(randBits(16))));
		prog.push_back(encI(opLui, 5'd12, 5'd0, 16'(randBits(16))));
		startProgram();
		finishProgram();
	endtask

	task automatic dependentChains();
		prog.delete();
		loadConst(5'd1, randBits(32));
		loadConst(5'd2, randBits(32));
		prog.push_back(encR(fnAdd, 5'd3, 5'd1, 5'd2));
		prog.push_back(encR(fnSub, 5'd4, 5'd3, 5'd1));
		prog.push_back(encR(fnAnd, 5'd5, 5'd4, 5'd3));
		prog.push_back(encR(fnOr, 5'd6, 5'd5, 5'd2));
		prog.push_back(encR(fnAdd, 5'd7, 5'd6, 5'd6));
		prog.push_back(encR(fnSlt, 5'd8, 5'd7, 5'd6));
		prog.push_back(encR(fnSub, 5'd9, 5'd8, 5'd7));
		prog.push_back(encR(fnAdd, 5'd9, 5'd9, 5'd9));
		startProgram();
		finishProgram();
	endtask

	task automatic storeThenLoad();
		word base;
		prog.delete();
		base = randBits(8) << 2;
		loadConst(5'd1, randBits(32));
		prog.push_back(encI(opOri, 5'd2, 5'd0, base[15:0]));
		prog.push_back(encI(opSw, 5'd1, 5'd2, 16'd4));
		prog.push_back(encI(opLw, 5'd3, 5'd2, 16'd4));
		prog.push_back(encR(fnAdd, 5'd4, 5'd3, 5'd1));
		prog.push_back(encI(opLw, 5'd5, 5'd2, 16'd8));
		// Store data only ready in writeback
		prog.push_back(encI(opSw, 5'd5, 5'd2, 16'd12));
		prog.push_back(encI(opLw, 5'd6, 5'd2, 16'd12));
		prog.push_back(encR(fnSub, 5'd7, 5'd6, 5'd5));
		prog.push_back(encI(opSw, 5'd7, 5'd2, 16'd16));
		startProgram();
		finishProgram();
	endtask

	task automatic branchesAndJumps();
		logic [15:0] imm;
		prog.delete();
		imm = 16'(randBits(16)) | 16'h8000;
		prog.push_back(encI(opOri, 5'd1, 5'd0, imm));
		prog.push_back(encI(opOri, 5'd2, 5'd0, imm));
		prog.push_back(encI(opBeq, 5'd2, 5'd1, 16'd2));
		prog.push_back(encI(opOri, 5'd3, 5'd0, 16'h0011));
		// Skipped by the taken beq
		prog.push_back(encI(opOri, 5'd4, 5'd0, 16'h0022));
		prog.push_back(encI(opOri, 5'd5, 5'd0, 16'h0033));
		// Would skip the write of r7 if taken
		prog.push_back(encI(opBeq, 5'd0, 5'd1, 16'd2));
		prog.push_back(encI(opOri, 5'd6, 5'd0, 16'h0044));
		prog.push_back(encI(opOri, 5'd7, 5'd0, 16'h0055));
		prog.push_back(encJal(resetPc + 32'd52));
		prog.push_back(encI(opOri, 5'd8, 5'd0, 16'h0066));
		// Return point of the subroutine
		prog.push_back(encI(opOri, 5'd9, 5'd0, 16'h0077));
		prog.push_back(encI(opBeq, 5'd0, 5'd0, 16'd4));
		// Subroutine
		prog.push_back(encR(fnOr, 5'd20, 5'd31, 5'd0));
		prog.push_back(encR(fnJr, 5'd0, 5'd20, 5'd0));
		prog.push_back(encI(opOri, 5'd11, 5'd0, 16'h0088));
		// Skipped by the jr
		prog.push_back(encI(opOri, 5'd12, 5'd0, 16'h0099));
		prog.push_back(encI(opOri, 5'd13, 5'd0, 16'h00aa));
		startProgram();
		finishProgram();
	endtask

	initial begin
		rstN = 1'b0;
		prog.delete();
		loadMemories();
		resetSequence();
		independentAlu();
		dependentChains();
		storeThenLoad();
		branchesAndJumps();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- tb.f
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/memWriteback.sv
hdl/cpuTop.sv
dv/cpuTop_properties.sv
dv/cpuTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the cpuTb simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f tb.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
exit 0
